// File: Makefile
# Verilator lint, build and run for the uart link testbench
VERILATOR ?= verilator
TOP       ?= uart_link_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sources.f
uart_pkg.sv
uart_rx.sv
uart_tx.sv
uart_controller.sv
uart_link_top.sv
tb_clock.sv
uart_link_assertions.sv
uart_link_tb.sv

// File: tb_clock.sv
// free running clock source for the testbench
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 100 // full clock period
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk; // 50/50 duty
  end

endmodule

// File: uart_controller.sv
// command decoder for host bytes and byte sequencer for core result frames
`timescale 1ns/1ps

module uart_controller import uart_pkg::*; (
  input  logic   i_CLK,
  input  logic   i_RST,
  input  logic   i_core_busy, // core running, selects accept rules
  // receiver side
  input  byte_t  i_rx_byte,
  input  logic   i_rx_strobe,
  // frame from the core
  input  frame_t i_tx_frame,
  input  logic   i_tx_valid,
  output logic   o_tx_ready,
  // command to the core
  output cmd_t   o_cmd,
  output logic   o_cmd_valid,
  // transmitter side
  output byte_t  o_tx_byte,
  output logic   o_tx_start,
  input  logic   i_tx_done
);

  ctrl_state_e r_state;
  ctrl_state_e w_next;
  logic        r_ready;  // idle and able to take a frame
  byte_t       r_opcode; // read opcode waiting for its address
  frame_t      r_frame;  // frame being sent, top byte first
  len_t        r_count;  // bytes still to send
  len_t        w_len;    // byte count from header, zero drops

  logic w_hs;         // frame handshake this cycle
  logic w_take_one;   // accepted single-byte command
  logic w_take_rd;    // accepted read opcode
  logic w_take_addr;  // address byte of a read
  logic w_last_done;  // last byte of the frame finished

  // ================================================
  // host byte decode
  // ================================================
  always_comb begin
    w_take_one = 1'b0;
    w_take_rd  = 1'b0;
    if (r_state == IDLE && i_rx_strobe) begin
      if (i_core_busy) begin
        w_take_one = (i_rx_byte == OP_STOP); // only stop while busy
      end else begin
        w_take_one = (i_rx_byte == OP_RUN);
        w_take_rd  = (i_rx_byte == OP_MPR_RD) || (i_rx_byte == OP_ADS_RD);
      end
    end
  end

  assign w_take_addr = (r_state == RX_ADDR) && i_rx_strobe;

  // host byte beats a frame in the same cycle
  assign o_tx_ready = r_ready && !i_rx_strobe;
  assign w_hs       = o_tx_ready && i_tx_valid;

  // header -> byte count
  always_comb begin
    case (r_frame[79:72])
      HDR_ADS_DATA:                       w_len = LEN_LONG;
      HDR_MPR_DATA, OP_MPR_RD, OP_ADS_RD: w_len = LEN_SHORT;
      default:                            w_len = '0; // unknown, drop
    endcase
  end

  assign w_last_done = (r_state == TX_WAIT) && i_tx_done && (r_count == len_t'(1));

  // transmitter gets the top byte while loading
  assign o_tx_start = (r_state == TX_LOAD);
  assign o_tx_byte  = r_frame[79:72];

  // ================================================
  // next state
  // ================================================
  always_comb begin
    w_next = r_state;
    case (r_state)
      IDLE: begin
        if (i_rx_strobe) begin
          if (w_take_rd) w_next = RX_ADDR; // else stays idle
        end else if (w_hs) begin
          w_next = TX_CLASSIFY;
        end
      end
      RX_ADDR:     if (i_rx_strobe) w_next = IDLE;
      TX_CLASSIFY: w_next = (w_len == '0) ? IDLE : TX_LOAD;
      TX_LOAD:     w_next = TX_WAIT; // one start pulse per byte
      TX_WAIT: begin
        if (i_tx_done) w_next = w_last_done ? IDLE : TX_LOAD;
      end
      default:     w_next = IDLE;
    endcase
  end

  // ================================================
  // control registers
  // ================================================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state     <= IDLE;
      r_ready     <= 1'b0;
      r_count     <= '0;
      o_cmd_valid <= 1'b0;
    end else begin
      r_state     <= w_next;
      r_ready     <= (w_next == IDLE); // rises again at end of frame
      o_cmd_valid <= w_take_one || w_take_addr;
      if (r_state == TX_CLASSIFY)           r_count <= w_len;
      else if (r_state == TX_WAIT && i_tx_done) r_count <= r_count - 1'b1;
    end
  end

  // payload, held between strobes
  always_ff @(posedge i_CLK) begin
    if (w_take_one) begin
      o_cmd.opcode <= i_rx_byte;
      o_cmd.addr   <= '0; // run/stop carry no address
    end
    if (w_take_rd) r_opcode <= i_rx_byte;
    if (w_take_addr) begin
      o_cmd.opcode <= r_opcode;
      o_cmd.addr   <= i_rx_byte;
    end
    if (w_hs) begin
      r_frame <= i_tx_frame;
    end else if (r_state == TX_WAIT && i_tx_done) begin
      r_frame <= {r_frame[71:0], 8'h00}; // next byte to the top
    end
  end

endmodule

// File: uart_link_assertions.sv
// concurrent checks on the command controller, bound into uart_controller
`timescale 1ns/1ps

module uart_link_assertions import uart_pkg::*; (
  input logic        i_CLK,
  input logic        i_RST,
  input ctrl_state_e i_state,     // controller FSM state
  input logic        i_cmd_valid,
  input logic        i_tx_ready,
  input logic        i_tx_valid,
  input logic        i_tx_start,
  input logic        i_txd        // serial line at the top level
);

  int unsigned fail_cnt = 0; // failed assertion count

  // ==================================================
  // strobes and handshake
  // ==================================================
  assert property (@(posedge i_CLK) disable iff (i_RST) i_cmd_valid |=> !i_cmd_valid)
    else begin
      $error("o_cmd_valid stayed high for more than one cycle");
      fail_cnt++;
    end

  assert property (@(posedge i_CLK) disable iff (i_RST) (i_tx_ready && i_tx_valid) |=> !i_tx_ready)
    else begin
      $error("o_tx_ready still high in the cycle after a frame handshake");
      fail_cnt++;
    end

  // start pulse only while the transmitter is free, start bit follows
  assert property (@(posedge i_CLK) disable iff (i_RST) i_tx_start |=> !i_txd)
    else begin
      $error("o_tx_start not followed by a start bit on o_uart_txd");
      fail_cnt++;
    end

  // line idles high unless a byte is on it
  assert property (@(posedge i_CLK) disable iff (i_RST) (i_state != TX_WAIT) |-> i_txd)
    else begin
      $error("o_uart_txd low while no byte is in progress");
      fail_cnt++;
    end

endmodule

// File: uart_link_tb.sv
// testbench top: host uart model, core frame model, lcg payloads, watchdog
`timescale 1ns/1ps

module uart_link_tb import uart_pkg::*; ();

  localparam int CLKS_PER_BIT = 8; // short bits for simulation
  localparam int N_TESTS      = 6;
  localparam int WATCHDOG     = N_TESTS * 12 * 10 * CLKS_PER_BIT + 2000; // cycles
  localparam int WAIT_LIMIT   = 12 * 10 * CLKS_PER_BIT; // longest single wait

  logic        clk;
  logic        rst;
  logic        rxd;       // host -> dut line
  logic        txd;       // dut -> host line
  logic        core_busy;
  frame_t      tx_frame;
  logic        tx_valid;
  logic        tx_ready;
  cmd_t        cmd;
  logic        cmd_valid;
  cmd_t        cmd_q[$];  // command strobes seen
  byte_t       line_q[$]; // bytes decoded from the tx line
  byte_t       exp_q[$];  // bytes the tx line should carry
  logic [31:0] lcg_state;

  tb_clock #(.PERIOD_NS(100)) i_clock (.o_clk(clk));

  uart_link_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_dut (
    .i_CLK(clk), .i_RST(rst), .i_uart_rxd(rxd), .o_uart_txd(txd),
    .i_core_busy(core_busy), .i_tx_frame(tx_frame), .i_tx_valid(tx_valid),
    .o_tx_ready(tx_ready), .o_cmd(cmd), .o_cmd_valid(cmd_valid)
  );

  bind uart_controller uart_link_assertions i_checks (
    .i_CLK(i_CLK), .i_RST(i_RST), .i_state(r_state), .i_cmd_valid(o_cmd_valid),
    .i_tx_ready(o_tx_ready), .i_tx_valid(i_tx_valid), .i_tx_start(o_tx_start),
    .i_txd(uart_link_tb.i_dut.o_uart_txd)
  );

  // ==================================================
  // helpers
  // ==================================================
  function automatic byte_t rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24]; // upper bits, better spread
  endfunction

  function automatic frame_t make_frame(input byte_t hdr);
    frame_t f;
    f = '0;
    f[79:72] = hdr;
    for (int i = 1; i < 10; i++) f[79 - 8*i -: 8] = rand_byte();
    return f;
  endfunction

  // bytes on the line per header class
  function automatic int sent_len(input byte_t hdr);
    if (hdr == HDR_ADS_DATA) return int'(LEN_LONG);
    if (hdr == HDR_MPR_DATA || hdr == OP_MPR_RD || hdr == OP_ADS_RD) return int'(LEN_SHORT);
    return 0; // unknown header, dropped
  endfunction

  function automatic void expect_frame(input frame_t f);
    for (int i = 0; i < sent_len(f[79:72]); i++) exp_q.push_back(f[79 - 8*i -: 8]);
  endfunction

  task automatic check_val(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic idle_bits(input int n);
    repeat (n * CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic set_busy(input logic busy);
    @(posedge clk);
    #10 core_busy = busy;
  endtask

  task automatic send_byte(input byte_t data);
    logic [9:0] bits;
    bits = {1'b1, data, 1'b0}; // stop, data, start
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #10 rxd = bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // n strobes expected, last one carrying op/addr
  task automatic expect_cmds(input int n, input byte_t op, input byte_t addr);
    int waited;
    waited = 0;
    while (cmd_q.size() < n) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) stop_on_timeout("command strobe never came");
    end
    idle_bits(2); // room for an extra strobe
    check_val("o_cmd_valid count", n, cmd_q.size());
    if (n > 0) begin
      check_val("o_cmd.opcode", int'(op), int'(cmd_q[n-1].opcode));
      check_val("o_cmd.addr", int'(addr), int'(cmd_q[n-1].addr));
    end
    cmd_q.delete();
  endtask

  task automatic read_register(input byte_t op);
    byte_t addr;
    addr = rand_byte();
    send_byte(op);
    expect_cmds(0, op, addr); // opcode alone gives nothing
    send_byte(addr);
    expect_cmds(1, op, addr);
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) stop_on_timeout("o_tx_ready stayed low");
    end while (!tx_ready);
  endtask

  task automatic offer_frame(input frame_t f);
    @(posedge clk);
    #10;
    tx_frame = f;
    tx_valid = 1'b1;
    wait_ready(); // edge with ready high is the transfer
    #10 tx_valid = 1'b0;
  endtask

  task automatic compare_line();
    check_val("o_uart_txd byte count", exp_q.size(), line_q.size());
    foreach (exp_q[i]) check_val("o_uart_txd byte", int'(exp_q[i]), int'(line_q[i]));
    exp_q.delete();
    line_q.delete();
  endtask

  task automatic run_frame(input frame_t f);
    expect_frame(f);
    offer_frame(f);
    wait_ready(); // end of frame or drop
    compare_line();
  endtask

  // ==================================================
  // monitors
  // ==================================================
  always @(posedge clk) begin
    if (cmd_valid) cmd_q.push_back(cmd);
  end

  initial begin : line_monitor
    byte_t data;
    forever begin
      @(posedge clk);
      if (!rst && !txd) begin
        repeat (CLKS_PER_BIT / 2) @(posedge clk); // middle of start bit
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          data[i] = txd; // lsb first
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        check_val("o_uart_txd stop bit", 1, int'(txd));
        line_q.push_back(data);
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG) @(posedge clk);
    $display("timeout: tests still running after %0d clock cycles", WATCHDOG);
    $display("Errors found");
    $fatal(1);
  end

  // ==================================================
  // test sequence
  // ==================================================
  initial begin : main
    frame_t f_first;
    frame_t f_second;
    rst       = 1'b1;
    rxd       = 1'b1; // line idle
    core_busy = 1'b0;
    tx_frame  = '0;
    tx_valid  = 1'b0;
    lcg_state = 32'hdef6_6055;
    repeat (10) @(posedge clk);
    #10 rst = 1'b0;
    wait_ready(); // ready rises right after reset
    check_val("o_uart_txd", 1, int'(txd));
    check_val("o_cmd_valid", 0, int'(cmd_valid));
    // idle core: run yes, stop no
    send_byte(OP_RUN);
    expect_cmds(1, OP_RUN, 8'h00);
    send_byte(OP_STOP);
    expect_cmds(0, OP_STOP, 8'h00);
    // busy core: only stop
    set_busy(1'b1);
    send_byte(OP_STOP);
    expect_cmds(1, OP_STOP, 8'h00);
    send_byte(OP_RUN);
    expect_cmds(0, OP_RUN, 8'h00);
    send_byte(OP_MPR_RD);
    expect_cmds(0, OP_MPR_RD, 8'h00);
    send_byte(8'h41); // stray byte
    expect_cmds(0, 8'h41, 8'h00);
    set_busy(1'b0);
    read_register(OP_ADS_RD);
    read_register(OP_MPR_RD);
    // frames, one per header class
    run_frame(make_frame(HDR_ADS_DATA));
    run_frame(make_frame(HDR_MPR_DATA));
    run_frame(make_frame(OP_MPR_RD));
    run_frame(make_frame(OP_ADS_RD));
    run_frame(make_frame(8'h5A)); // unknown header
    // second frame held valid behind the first
    f_first  = make_frame(HDR_MPR_DATA);
    f_second = make_frame(HDR_ADS_DATA);
    expect_frame(f_first);
    expect_frame(f_second);
    offer_frame(f_first);
    offer_frame(f_second);
    wait_ready();
    idle_bits(20); // a repeat would show up here
    compare_line();
    if (i_dut.i_uart_controller.i_checks.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("controller assertions failed %0d times", i_dut.i_uart_controller.i_checks.fail_cnt);
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: uart_link_top.sv
// top level, receiver and transmitter around the command controller
`timescale 1ns/1ps

module uart_link_top import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 217 // 25 MHz / 115200 baud
) (
  input  logic   i_CLK,
  input  logic   i_RST,
  input  logic   i_uart_rxd,  // from host
  output logic   o_uart_txd,  // to host
  input  logic   i_core_busy,
  input  frame_t i_tx_frame,
  input  logic   i_tx_valid,
  output logic   o_tx_ready,
  output cmd_t   o_cmd,
  output logic   o_cmd_valid
);

  byte_t rx_byte;
  logic  rx_strobe;
  byte_t tx_byte;
  logic  tx_start;
  logic  tx_done;

  // ================================================
  // serial in, control, serial out
  // ================================================
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
    .i_CLK(i_CLK), .i_RST(i_RST), .i_rxd(i_uart_rxd),
    .o_byte(rx_byte), .o_strobe(rx_strobe)
  );

  uart_controller i_uart_controller (
    .i_CLK(i_CLK), .i_RST(i_RST), .i_core_busy(i_core_busy),
    .i_rx_byte(rx_byte), .i_rx_strobe(rx_strobe),
    .i_tx_frame(i_tx_frame), .i_tx_valid(i_tx_valid), .o_tx_ready(o_tx_ready),
    .o_cmd(o_cmd), .o_cmd_valid(o_cmd_valid),
    .o_tx_byte(tx_byte), .o_tx_start(tx_start), .i_tx_done(tx_done)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
    .i_CLK(i_CLK), .i_RST(i_RST), .i_start(tx_start), .i_byte(tx_byte),
    .o_txd(o_uart_txd), .o_done(tx_done)
  );

endmodule

// File: uart_pkg.sv
// shared types, opcodes, frame lengths and controller states for the uart link
package uart_pkg;

  // ================================================
  // basic widths
  // ================================================
  typedef logic [7:0]  byte_t;  // one uart data byte
  typedef logic [79:0] frame_t; // result frame, header in [79:72]
  typedef logic [3:0]  len_t;   // bytes left in a frame

  // command handed to the sensor core
  typedef struct packed {
    byte_t opcode; // host command char
    byte_t addr;   // register address, zero for run/stop
  } cmd_t;

  // ================================================
  // host command bytes
  // ================================================
  localparam byte_t OP_RUN    = 8'h52; // 'R'
  localparam byte_t OP_STOP   = 8'h53; // 'S'
  localparam byte_t OP_MPR_RD = 8'h6D; // 'm', address byte follows
  localparam byte_t OP_ADS_RD = 8'h61; // 'a', address byte follows

  // result frame headers from the core
  localparam byte_t HDR_MPR_DATA = 8'hBB;
  localparam byte_t HDR_ADS_DATA = 8'hAA;
  // register-read replies reuse OP_MPR_RD / OP_ADS_RD as header

  // ================================================
  // bytes sent per frame class
  // ================================================
  localparam len_t LEN_SHORT = 4'd3;  // mpr data and register replies
  localparam len_t LEN_LONG  = 4'd10; // full ads data frame

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,        // waiting for host byte or core frame
    RX_ADDR,     // read-register opcode held, waiting for address
    TX_CLASSIFY, // frame latched, header being decoded
    TX_LOAD,     // top byte handed to the transmitter
    TX_WAIT      // byte on the line, waiting for done
  } ctrl_state_e;

endpackage

// File: uart_rx.sv
// 8N1 uart receiver with oversampling counter and glitch-filtered start bit
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 217 // clocks per serial bit
) (
  input  logic  i_CLK,
  input  logic  i_RST,
  input  logic  i_rxd,    // serial line, idle high
  output byte_t o_byte,   // valid while o_strobe is high
  output logic  o_strobe  // one cycle per good frame
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(CLKS_PER_BIT / 2 - 1); // half a bit

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  logic             r_meta;  // first sync stage
  logic             r_sync;  // synchronized line
  rx_state_e        r_state;
  logic [CNT_W-1:0] r_cnt;   // clocks within the current bit
  logic [2:0]       r_idx;   // data bit number
  byte_t            r_shift; // data bits, lsb arrives first

  // ================================================
  // line synchronizer
  // ================================================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_meta <= 1'b1; // idle level
      r_sync <= 1'b1;
    end else begin
      r_meta <= i_rxd;
      r_sync <= r_meta;
    end
  end

  // ================================================
  // frame FSM
  // ================================================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state  <= RX_IDLE;
      r_cnt    <= '0;
      r_idx    <= '0;
      o_strobe <= 1'b0;
    end else begin
      o_strobe <= 1'b0; // single cycle pulse
      case (r_state)
        RX_IDLE: begin
          r_cnt <= '0;
          if (!r_sync) r_state <= RX_START; // falling edge seen
        end
        RX_START: begin
          if (r_sync) begin
            r_state <= RX_IDLE; // too short, glitch
          end else if (r_cnt == CNT_MID) begin
            r_cnt   <= '0; // now in middle of start bit
            r_idx   <= '0;
            r_state <= RX_DATA;
          end else begin
            r_cnt <= r_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (r_cnt == CNT_LAST) begin
            r_cnt <= '0;
            if (r_idx == 3'd7) r_state <= RX_STOP;
            else               r_idx   <= r_idx + 1'b1;
          end else begin
            r_cnt <= r_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (r_cnt == CNT_LAST) begin
            r_state  <= RX_IDLE;
            o_strobe <= r_sync; // bad stop level drops the byte
          end else begin
            r_cnt <= r_cnt + 1'b1;
          end
        end
        default: r_state <= RX_IDLE;
      endcase
    end
  end

  // data path, sampled mid-bit
  always_ff @(posedge i_CLK) begin
    if (r_state == RX_DATA && r_cnt == CNT_LAST) r_shift <= {r_sync, r_shift[7:1]};
    if (r_state == RX_STOP && r_cnt == CNT_LAST && r_sync) o_byte <= r_shift;
  end

endmodule

// File: uart_tx.sv
// 8N1 uart transmitter, one done pulse per byte sent
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 217 // clocks per serial bit
) (
  input  logic  i_CLK,
  input  logic  i_RST,
  input  logic  i_start, // load i_byte, ignored while busy
  input  byte_t i_byte,
  output logic  o_txd,   // serial line, idle high
  output logic  o_done   // end of stop bit
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [3:0]       BIT_LAST = 4'd9; // start + 8 data + stop

  logic             r_busy;
  logic [CNT_W-1:0] r_cnt;   // clocks within the current bit
  logic [3:0]       r_idx;   // bit number on the line
  logic [9:0]       r_shift; // {stop, data, start}, bit 0 on the line

  assign o_txd = r_shift[0]; // straight from a flop, no glitches

  // ================================================
  // bit sequencer
  // ================================================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_busy  <= 1'b0;
      r_cnt   <= '0;
      r_idx   <= '0;
      r_shift <= '1; // line high out of reset
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (!r_busy) begin
        if (i_start) begin
          r_busy  <= 1'b1;
          r_cnt   <= '0;
          r_idx   <= '0;
          r_shift <= {1'b1, i_byte, 1'b0}; // start bit goes out next cycle
        end
      end else if (r_cnt == CNT_LAST) begin
        r_cnt   <= '0;
        r_shift <= {1'b1, r_shift[9:1]}; // refill with idle level
        if (r_idx == BIT_LAST) begin
          r_busy <= 1'b0; // stop bit finished
          o_done <= 1'b1;
        end else begin
          r_idx <= r_idx + 1'b1;
        end
      end else begin
        r_cnt <= r_cnt + 1'b1;
      end
    end
  end

  // busy window covers exactly 10 bit periods per byte

endmodule
